/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_fwd_mux.sv
ex_ctrl.sv
ex_stage.sv
ex_stage_props.sv
tb_ex_stage.sv

/* ex_alu.sv */
// Integer ALU: add/sub, logic, shifts, set-less-than and branch comparison flag
module ex_alu (
  input  logic                      alu_en_i,
  input  ex_pkg::alu_op_t           alu_operator_i,
  input  logic [ex_pkg::XLEN-1:0]   alu_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]   alu_operand_b_i,
  output logic [ex_pkg::XLEN-1:0]   alu_result_o,
  output logic                      alu_cmp_result_o
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  // Subtract by inverting b and carrying in one
  logic            sub_sel;
  logic [XLEN-1:0] adder_b;
  logic [XLEN-1:0] adder_result;

  assign sub_sel      = (alu_operator_i == ALU_SUB);
  assign adder_b      = sub_sel ? ~alu_operand_b_i : alu_operand_b_i;
  assign adder_result = alu_operand_a_i + adder_b + {{(XLEN-1){1'b0}}, sub_sel};

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  // Only the low five bits of b count
  logic [4:0]      shamt;
  logic [XLEN-1:0] sll_result;
  logic [XLEN-1:0] srl_result;
  logic [XLEN-1:0] sra_result;

  assign shamt      = alu_operand_b_i[4:0];
  assign sll_result = alu_operand_a_i << shamt;
  assign srl_result = alu_operand_a_i >> shamt;
  assign sra_result = $unsigned($signed(alu_operand_a_i) >>> shamt);

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  logic is_equal;
  logic is_less_s;
  logic is_less_u;

  assign is_equal  = (alu_operand_a_i == alu_operand_b_i);
  assign is_less_s = ($signed(alu_operand_a_i) < $signed(alu_operand_b_i));
  assign is_less_u = (alu_operand_a_i < alu_operand_b_i);

  // One flag shared by SLT* and the branch compares
  always_comb begin
    unique case (alu_operator_i)
      ALU_EQ:           alu_cmp_result_o = is_equal;
      ALU_NE:           alu_cmp_result_o = ~is_equal;
      ALU_SLT, ALU_LT:  alu_cmp_result_o = is_less_s;
      ALU_GE:           alu_cmp_result_o = ~is_less_s;
      ALU_SLTU, ALU_LTU: alu_cmp_result_o = is_less_u;
      ALU_GEU:          alu_cmp_result_o = ~is_less_u;
      default:          alu_cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_result_o = '0;
    // Idle ALU drives zero
    if (alu_en_i) begin
      unique case (alu_operator_i)
        ALU_ADD, ALU_SUB: alu_result_o = adder_result;
        ALU_AND:          alu_result_o = alu_operand_a_i & alu_operand_b_i;
        ALU_OR:           alu_result_o = alu_operand_a_i | alu_operand_b_i;
        ALU_XOR:          alu_result_o = alu_operand_a_i ^ alu_operand_b_i;
        ALU_SLL:          alu_result_o = sll_result;
        ALU_SRL:          alu_result_o = srl_result;
        ALU_SRA:          alu_result_o = sra_result;
        // Compares return the flag zero-extended
        default:          alu_result_o = {{(XLEN-1){1'b0}}, alu_cmp_result_o};
      endcase
    end
  end

endmodule

/* ex_ctrl.sv */
// Stage control: ex_ready/ex_valid stall logic and the EX/WB load write-back register
module ex_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_access_i,
  input  logic                          lsu_en_i,
  input  logic                          branch_in_ex_i,
  input  logic                          mult_ready_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          wb_ready_i,
  input  logic                          lsu_err_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0]  regfile_waddr_i,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::RF_ADDR_W-1:0]  regfile_waddr_wb_o
);

  ////////////////////////////////////////////////////////////
  // Ready and valid
  ////////////////////////////////////////////////////////////

  logic units_ready;
  logic any_unit_en;
  logic ex_valid;
  logic wb_we_d;

  // Multiplier, LSU and WB all able to move on
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_unit_en = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches finish in EX and never wait for WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;

  // Valid flows forward only, so it does not look at ex_ready
  assign ex_valid    = any_unit_en & units_ready;
  assign ex_valid_o  = ex_valid;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // LSU error kills the write-back
  assign wb_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid) begin
      // WB is ready whenever valid is high
      regfile_we_wb_o <= wb_we_d;
      if (wb_we_d) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB drained and nothing new, flush the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

endmodule

/* ex_fwd_mux.sv */
// Forwarding write-port data select: CSR over multiplier over ALU
module ex_fwd_mux (
  input  logic                      alu_en_i,
  input  logic                      mult_en_i,
  input  logic                      csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]   alu_result_i,
  input  logic [ex_pkg::XLEN-1:0]   mult_result_i,
  input  logic [ex_pkg::XLEN-1:0]   csr_rdata_i,
  output logic [ex_pkg::XLEN-1:0]   fw_wdata_o
);

  ////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////

  // CSR read data wins
  // Multiplier wins over the ALU
  // Nothing enabled gives zero
  always_comb begin
    if (csr_access_i) begin
      fw_wdata_o = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_wdata_o = mult_result_i;
    end else if (alu_en_i) begin
      fw_wdata_o = alu_result_i;
    end else begin
      fw_wdata_o = '0;
    end
  end

endmodule

/* ex_mult.sv */
// Multiplier: one-cycle low product, two-cycle high product with sequencer
module ex_mult (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mult_en_i,
  input  ex_pkg::mult_op_t          mult_operator_i,
  input  logic [ex_pkg::XLEN-1:0]   mult_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]   mult_operand_b_i,
  input  logic                      ex_ready_i,
  output logic [ex_pkg::XLEN-1:0]   mult_result_o,
  output logic                      mult_ready_o,
  output logic                      mult_multicycle_o
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////
  // Operand extension and product
  ////////////////////////////////////////////////////////////

  logic                     a_signed;
  logic                     b_signed;
  logic                     high_op;
  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [2*XLEN-1:0] product;

  // HSS signs both, HSU only a, HUU neither
  assign a_signed = (mult_operator_i == MUL_HSS) || (mult_operator_i == MUL_HSU);
  assign b_signed = (mult_operator_i == MUL_HSS);
  assign high_op  = (mult_operator_i != MUL_LO);

  // One extra bit carries the sign or a zero
  assign op_a_ext = {a_signed & mult_operand_a_i[XLEN-1], mult_operand_a_i};
  assign op_b_ext = {b_signed & mult_operand_b_i[XLEN-1], mult_operand_b_i};

  // 64-bit context keeps the modular product exact
  assign product  = op_a_ext * op_b_ext;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  mult_state_t     mult_state_q;
  mult_state_t     mult_state_d;
  logic            hi_load;
  logic [XLEN-1:0] product_hi_q;

  always_comb begin
    mult_state_d = mult_state_q;
    hi_load      = 1'b0;
    unique case (mult_state_q)
      MULT_IDLE: begin
        // High multiply spends one cycle computing
        if (mult_en_i && high_op) begin
          mult_state_d = MULT_HIGH;
          hi_load      = 1'b1;
        end
      end
      MULT_HIGH: begin
        // Leave once the stage takes the next instruction
        if (ex_ready_i) begin
          mult_state_d = MULT_IDLE;
        end
      end
      default: mult_state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_state_q <= MULT_IDLE;
    end else begin
      mult_state_q <= mult_state_d;
    end
  end

  // Upper word captured at the first edge
  always_ff @(posedge clk) begin
    if (hi_load) begin
      product_hi_q <= product[2*XLEN-1:XLEN];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Not ready only in the first cycle of a high multiply
  assign mult_ready_o      = ~((mult_state_q == MULT_IDLE) & mult_en_i & high_op);
  assign mult_multicycle_o = (mult_state_q == MULT_HIGH);

  always_comb begin
    if (mult_state_q == MULT_HIGH) begin
      mult_result_o = product_hi_q;
    end else if (mult_en_i) begin
      mult_result_o = product[XLEN-1:0];  // low word, valid for MUL_LO
    end else begin
      mult_result_o = '0;
    end
  end

endmodule

/* ex_pkg.sv */
// Shared widths, ALU and multiplier opcode enums, multiplier sequencer states
package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Register file address, 64 entries incl. FP side
  localparam int unsigned RF_ADDR_W = 6;

  ////////////////////////////////////////////////////////////
  // ALU opcodes
  ////////////////////////////////////////////////////////////

  // Arithmetic and logic first, then compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    // Set-less-than, result is the flag
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch compares
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_t;

  ////////////////////////////////////////////////////////////
  // Multiplier opcodes and sequencer
  ////////////////////////////////////////////////////////////

  // Low word, or high word with the given operand signedness
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HUU = 2'd2,
    MUL_HSU = 2'd3
  } mult_op_t;

  // Second cycle of a high multiply
  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_HIGH = 1'b1
  } mult_state_t;

endpackage

/* ex_stage.sv */
// Execute stage top: ALU, multiplier, forwarding mux and stage control
module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,

  // ALU from ID
  input  ex_pkg::alu_op_t               alu_operator_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_operand_b_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_operand_c_i,
  input  logic                          alu_en_i,

  // Multiplier from ID
  input  ex_pkg::mult_op_t              mult_operator_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_operand_b_i,
  input  logic                          mult_en_i,
  output logic                          mult_multicycle_o,

  // LSU
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_ready_ex_i,
  input  logic                          lsu_err_i,

  // ID-side control
  input  logic                          branch_in_ex_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                          regfile_alu_we_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0]  regfile_waddr_i,

  // CSR
  input  logic                          csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,

  // WB port
  output logic [ex_pkg::RF_ADDR_W-1:0]  regfile_waddr_wb_o,
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_wdata_wb_o,

  // Forwarding port to ID and RF
  output logic [ex_pkg::RF_ADDR_W-1:0]  regfile_alu_waddr_fw_o,
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::XLEN-1:0]       regfile_alu_wdata_fw_o,

  // Branch to IF
  output logic [ex_pkg::XLEN-1:0]       jump_target_o,
  output logic                          branch_decision_o,

  // Handshake
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  input  logic                          wb_ready_i
);

  import ex_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  ////////////////////////////////////////////////////////////
  // Pass-through
  ////////////////////////////////////////////////////////////

  assign branch_decision_o      = alu_cmp_result;
  assign jump_target_o          = alu_operand_c_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  // Load data goes straight to WB
  assign regfile_wdata_wb_o     = lsu_rdata_i;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .alu_en_i         (alu_en_i),
    .alu_operator_i   (alu_operator_i),
    .alu_operand_a_i  (alu_operand_a_i),
    .alu_operand_b_i  (alu_operand_b_i),
    .alu_result_o     (alu_result),
    .alu_cmp_result_o (alu_cmp_result)
  );

  // Sequencer leaves MULT_HIGH on the stage handshake
  ex_mult mult_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .mult_en_i         (mult_en_i),
    .mult_operator_i   (mult_operator_i),
    .mult_operand_a_i  (mult_operand_a_i),
    .mult_operand_b_i  (mult_operand_b_i),
    .ex_ready_i        (ex_ready_o),
    .mult_result_o     (mult_result),
    .mult_ready_o      (mult_ready),
    .mult_multicycle_o (mult_multicycle_o)
  );

  ex_fwd_mux fwd_mux_i (
    .alu_en_i      (alu_en_i),
    .mult_en_i     (mult_en_i),
    .csr_access_i  (csr_access_i),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .fw_wdata_o    (regfile_alu_wdata_fw_o)
  );

  ex_ctrl ctrl_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_en_i           (alu_en_i),
    .mult_en_i          (mult_en_i),
    .csr_access_i       (csr_access_i),
    .lsu_en_i           (lsu_en_i),
    .branch_in_ex_i     (branch_in_ex_i),
    .mult_ready_i       (mult_ready),
    .lsu_ready_ex_i     (lsu_ready_ex_i),
    .wb_ready_i         (wb_ready_i),
    .lsu_err_i          (lsu_err_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .ex_ready_o         (ex_ready_o),
    .ex_valid_o         (ex_valid_o),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o)
  );

endmodule

/* ex_stage_props.sv */
// Concurrent assertions on the ex_stage handshake, EX/WB register and multiplier state
module ex_stage_props (
  input logic                clk,
  input logic                rst_n,
  input logic                ex_valid_o,
  input logic                ex_ready_o,
  input logic                wb_ready_i,
  input logic                branch_in_ex_i,
  input logic                regfile_we_wb_o,
  input logic                mult_multicycle_o,
  input ex_pkg::mult_state_t mult_state_i
);

  import ex_pkg::*;

  // Nothing leaves EX while WB is busy
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> wb_ready_i)
    else $error("ex_valid_o high while wb_ready_i low");

  // Idle WB drains the EX/WB slot
  wb_flush: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ready_i && !ex_valid_o) |=> !regfile_we_wb_o)
    else $error("regfile_we_wb_o not cleared");

  // Multicycle flag only in the second cycle of a high multiply
  multicycle_state: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o |-> (mult_state_i == MULT_HIGH))
    else $error("mult_multicycle_o outside MULT_HIGH");

  // Branches never stall
  branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_o)
    else $error("ex_ready_o low with a branch in EX");

endmodule

bind ex_stage ex_stage_props props_i (
  .clk               (clk),
  .rst_n             (rst_n),
  .ex_valid_o        (ex_valid_o),
  .ex_ready_o        (ex_ready_o),
  .wb_ready_i        (wb_ready_i),
  .branch_in_ex_i    (branch_in_ex_i),
  .regfile_we_wb_o   (regfile_we_wb_o),
  .mult_multicycle_o (mult_multicycle_o),
  .mult_state_i      (mult_i.mult_state_q)
);

/* tb_ex_stage.sv */
// Testbench for ex_stage with clock, reset, stimulus, reference model, checker and summary
module tb_ex_stage;

  import ex_pkg::*;

  logic                 clk;
  logic                 rst_n;
  alu_op_t              alu_op;
  logic [XLEN-1:0]      alu_a, alu_b, alu_c;
  logic                 alu_en;
  mult_op_t             mult_op;
  logic [XLEN-1:0]      mult_a, mult_b;
  logic                 mult_en, mult_multicycle;
  logic                 lsu_en, lsu_ready, lsu_err, branch_in_ex;
  logic [XLEN-1:0]      lsu_rdata, csr_rdata;
  logic [RF_ADDR_W-1:0] alu_waddr, rf_waddr, waddr_wb, fw_waddr;
  logic                 alu_we, rf_we, csr_access, wb_ready;
  logic                 we_wb, fw_we, branch_dec, ex_ready, ex_valid;
  logic [XLEN-1:0]      wdata_wb, fw_wdata, jump_target;

  integer seed = 32'h8606_a1a5;
  int     errors = 0;
  int     checks = 0;
  int     timeouts = 0;
  int     cycles;
  logic   chk_alu = 1'b0;

  ex_stage ex_stage_i (
    .clk(clk), .rst_n(rst_n),
    .alu_operator_i(alu_op), .alu_operand_a_i(alu_a), .alu_operand_b_i(alu_b),
    .alu_operand_c_i(alu_c), .alu_en_i(alu_en),
    .mult_operator_i(mult_op), .mult_operand_a_i(mult_a), .mult_operand_b_i(mult_b),
    .mult_en_i(mult_en), .mult_multicycle_o(mult_multicycle),
    .lsu_en_i(lsu_en), .lsu_rdata_i(lsu_rdata), .lsu_ready_ex_i(lsu_ready),
    .lsu_err_i(lsu_err), .branch_in_ex_i(branch_in_ex),
    .regfile_alu_waddr_i(alu_waddr), .regfile_alu_we_i(alu_we),
    .regfile_we_i(rf_we), .regfile_waddr_i(rf_waddr),
    .csr_access_i(csr_access), .csr_rdata_i(csr_rdata),
    .regfile_waddr_wb_o(waddr_wb), .regfile_we_wb_o(we_wb), .regfile_wdata_wb_o(wdata_wb),
    .regfile_alu_waddr_fw_o(fw_waddr), .regfile_alu_we_fw_o(fw_we),
    .regfile_alu_wdata_fw_o(fw_wdata),
    .jump_target_o(jump_target), .branch_decision_o(branch_dec),
    .ex_ready_o(ex_ready), .ex_valid_o(ex_valid), .wb_ready_i(wb_ready)
  );

  // 40 unit period
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////

  // Unit 0 is the ALU result, 1 the multiplier word, 2 the compare flag
  function automatic logic [XLEN-1:0] ref_result(input int unit, input logic [3:0] op,
                                                 input logic [XLEN-1:0] a, b);
    logic        flag;
    logic [63:0] ax, bx, prod;
    flag = 1'b0;
    case (op)
      4'h8, 4'hC: flag = ($signed(a) < $signed(b));
      4'h9, 4'hE: flag = (a < b);
      4'hA:       flag = (a == b);
      4'hB:       flag = (a != b);
      4'hD:       flag = ($signed(a) >= $signed(b));
      4'hF:       flag = (a >= b);
      default:    flag = 1'b0;
    endcase
    if (unit == 2) return {31'b0, flag};
    if (unit == 1) begin
      // Sign of a for HSS and HSU, sign of b for HSS only
      ax   = {((op == 4'd1 || op == 4'd3) && a[31]) ? 32'hFFFF_FFFF : 32'h0, a};
      bx   = {((op == 4'd1) && b[31]) ? 32'hFFFF_FFFF : 32'h0, b};
      prod = ax * bx;
      return (op == 4'd0) ? prod[31:0] : prod[63:32];
    end
    case (op)
      4'h0:    return a + b;
      4'h1:    return a - b;
      4'h2:    return a & b;
      4'h3:    return a | b;
      4'h4:    return a ^ b;
      4'h5:    return a << b[4:0];
      4'h6:    return a >> b[4:0];
      // Logical shift with the vacated top bits filled from the sign
      4'h7:    return (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
      default: return {31'b0, flag};
    endcase
  endfunction

  task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  // Count low-ready cycles until the stage accepts
  task automatic wait_ex_ready(output int n);
    n = 0;
    @(negedge clk);
    while (!ex_ready && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!ex_ready) begin
      timeouts++;
      $display("Timeout: the stage never raised ex_ready");
    end
  endtask

  // Everything idle with both neighbors ready
  task automatic drive_idle();
    alu_en       = 0;
    mult_en      = 0;
    lsu_en       = 0;
    csr_access   = 0;
    branch_in_ex = 0;
    rf_we        = 0;
    lsu_err      = 0;
    wb_ready     = 1;
    lsu_ready    = 1;
    alu_we       = 0;
  endtask

  // ALU forwarding and branch checker sampled mid-cycle
  always @(negedge clk) begin
    if (chk_alu) begin
      check_value(fw_wdata, ref_result(0, alu_op, alu_a, alu_b), "ALU forwarding data");
      check_value({31'b0, fw_we}, {31'b0, alu_we}, "forwarding we");
      check_value({26'b0, fw_waddr}, {26'b0, alu_waddr}, "forwarding waddr");
      if (alu_op >= ALU_SLT) begin
        check_value({31'b0, branch_dec}, ref_result(2, alu_op, alu_a, alu_b), "branch flag");
        check_value(jump_target, alu_c, "jump target");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Multiplies with the low word at once and high words after one stall cycle
  task automatic run_multiplies();
    for (int op = 0; op < 4; op++) begin
      repeat (3) begin
        @(posedge clk);
        #2;
        mult_en = 1;
        mult_op = mult_op_t'(op);
        mult_a  = $random(seed);
        mult_b  = $random(seed);
        wait_ex_ready(cycles);
        if (timeouts != 0) begin
          return;
        end
        check_value(cycles, (op == 0) ? 0 : 1, "multiply stall cycles");
        check_value(fw_wdata, ref_result(1, 4'(op), mult_a, mult_b), "multiply result");
        check_value({31'b0, mult_multicycle}, (op == 0) ? 0 : 1, "multicycle flag");
      end
    end
  endtask

  // Forwarding priority, load write-back and WB back-pressure
  task automatic directed_checks();
    @(posedge clk);
    #2;
    drive_idle();

    // Forwarding priority
    alu_en     = 1;
    mult_en    = 1;
    csr_access = 1;
    mult_op    = MUL_LO;
    csr_rdata  = $random(seed);
    @(negedge clk);
    check_value(fw_wdata, csr_rdata, "CSR over multiplier and ALU");
    @(posedge clk);
    #2 csr_access = 0;
    @(negedge clk);
    check_value(fw_wdata, ref_result(1, 4'd0, mult_a, mult_b), "multiplier over ALU");

    // Load write-back
    @(posedge clk);
    #2;
    drive_idle();
    lsu_en    = 1;
    rf_we     = 1;
    rf_waddr  = 6'h2B;
    lsu_rdata = $random(seed);
    @(negedge clk);
    check_value({31'b0, ex_valid}, 1, "load valid");
    check_value(wdata_wb, lsu_rdata, "load data to WB");
    @(posedge clk);
    #2 drive_idle();
    @(negedge clk);
    check_value({31'b0, we_wb}, 1, "load write-back enable");
    check_value({26'b0, waddr_wb}, 32'h2B, "load write-back address");
    @(negedge clk);
    check_value({31'b0, we_wb}, 0, "write-back flush");
    @(posedge clk);
    #2;
    lsu_en  = 1;
    rf_we   = 1;
    lsu_err = 1;
    @(posedge clk);
    #2 drive_idle();
    @(negedge clk);
    check_value({31'b0, we_wb}, 0, "load error suppresses write-back");

    // Back-pressure from WB and then a branch
    @(posedge clk);
    #2;
    lsu_en = 1;
    rf_we  = 1;
    @(posedge clk);
    #2;
    drive_idle();
    alu_en   = 1;
    wb_ready = 0;
    @(negedge clk);
    check_value({30'b0, ex_valid, ex_ready}, 0, "stall with WB busy");
    @(negedge clk);
    check_value({31'b0, we_wb}, 1, "write-back holds under stall");
    @(posedge clk);
    #2 branch_in_ex = 1;
    @(negedge clk);
    check_value({31'b0, ex_ready}, 1, "branch ready under stall");
    @(posedge clk);
    #2 drive_idle();
    repeat (2) @(posedge clk);
  endtask

  initial begin
    clk       = 0;
    rst_n     = 0;
    drive_idle();
    alu_op    = ALU_ADD;
    mult_op   = MUL_LO;
    alu_a     = 0;
    alu_b     = 0;
    alu_c     = 0;
    mult_a    = 0;
    mult_b    = 0;
    lsu_rdata = 0;
    csr_rdata = 0;
    alu_waddr = 0;
    rf_waddr  = 0;
    repeat (5) @(posedge clk);
    #2 rst_n = 1;

    // Random ALU operations with half the compares on equal operands
    repeat (200) begin
      @(posedge clk);
      #2;
      alu_en    = 1;
      chk_alu   = 1;
      alu_we    = 1'($random(seed));
      alu_op    = alu_op_t'($random(seed) & 15);
      alu_a     = $random(seed);
      alu_b     = $random(seed);
      alu_c     = $random(seed);
      alu_waddr = RF_ADDR_W'($random(seed));
      if ($random(seed) & 1) begin
        alu_b = alu_a;
      end
    end
    @(posedge clk);
    #2;
    chk_alu = 0;
    drive_idle();

    run_multiplies();
    if (timeouts == 0) begin
      directed_checks();
    end
    finish_run();
  end

endmodule
